// File: verilog.f
+incdir+verification
source/video_timing_pkg.sv
source/video_regs_pkg.sv
source/apb_reg_fsm.sv
source/raster_counter.sv
source/char_fetch.sv
source/pixel_shifter.sv
source/video_top.sv
verification/video_tb.sv

// File: verification/video_model.svh
// mirrors of the video memories and the two control registers
logic [7:0] m_dsp  [0:2047];
logic [7:0] m_font [0:4095];
logic [7:0] m_opreg;
logic [7:0] m_modreg;
logic       m_frame_80;                 // mode in force for the frame on screen

localparam int HS_FIRST = 659;          // h_sync high clocks, as col*8 + pix
localparam int HS_LAST  = 754;
localparam int VS_LINE  = 489;          // v_sync starts on the second clock here

// 0 display, 1 font, 2 opreg, 3 modreg, 4 unmapped
function automatic int addr_region(input logic [13:0] a);
   if (a < 14'h0800)
      return 0;
   if (a >= 14'h1000 && a < 14'h2000)
      return 1;
   if (a == 14'h2000)
      return 2;
   if (a == 14'h2004)
      return 3;
   return 4;
endfunction

function automatic void model_write(input logic [13:0] a, input logic [7:0] d);
   case (addr_region(a))
      0:       m_dsp[a[10:0]] = d;
      1:       m_font[a[11:0]] = d;
      2:       m_opreg = d;
      3:       m_modreg = d;
      default: ;
   endcase
endfunction

// {active, fetched, byte loaded} for column c of frame line l
function automatic logic [9:0] col_load(input int l, input int c);
   int         dc, dr, ln;
   logic       act, fetch, inv, alt, invv, enalt;
   logic [7:0] b, v;
   logic [3:0] fr;
   invv  = m_opreg[3];
   enalt = m_modreg[3];
   if (m_frame_80)
   begin
      dc  = c;
      dr  = l / ROWS_80;
      ln  = l % ROWS_80;
      act = dc < 80 && dr < 24;
   end
   else
   begin
      dc  = c - COL_OFS_64;                // centered window
      dr  = l / ROWS_64 - ROW_OFS_64;
      ln  = l % ROWS_64;
      act = dc >= 0 && dc < 64 && dr >= 0 && dr < 16;
   end
   fetch = act && (!m_modreg[2] || dc % 2 == 0);   // even columns only in double width
   v = 8'h00;
   if (fetch)
   begin
      b   = m_dsp[m_frame_80 ? dr * 80 + dc : dr * 64 + dc];
      fr  = 4'(ln / 2);                    // two scan lines per font row
      inv = b[7];
      alt = b[6];
      if (b[7:6] == 2'b10 && !invv)
      begin
         case (fr[3:2])                     // 2x3 cells, even cell on the left
            2'd0:    v = {{4{b[0]}}, {4{b[1]}}};
            2'd1:    v = {{4{b[2]}}, {4{b[3]}}};
            2'd2:    v = {{4{b[4]}}, {4{b[5]}}};
            default: v = 8'h00;
         endcase
      end
      else
      begin
         v = m_font[{inv & ~invv, alt & ~(enalt & inv), b[5:0], fr}];
         if (fr >= GLYPH_ROWS)
            v = 8'h00;
         if (inv && invv)
            v = ~v;
      end
   end
   return {act, fetch, v};
endfunction

// pixel during clock p of frame line l, first pixel of column c at c*8+5
function automatic logic expected_pixel(input int l, input int p);
   int         q, c, k;
   logic [9:0] ld;
   logic       dw;
   dw = m_modreg[2];
   q  = p - 5;
   if (q < 0)
      return 1'b0;                          // col 99 of the line before is blank
   c  = q / 8;
   k  = q % 8;
   ld = col_load(l, c);
   if (dw && ld[9] && !ld[8])
   begin
      ld = col_load(l, c - 1);              // even column still shifting out
      k  = k + 8;
   end
   return dw ? ld[7 - k / 2] : ld[7 - k];
endfunction

function automatic logic expected_hsync(input int p);
   return p >= HS_FIRST && p <= HS_LAST;
endfunction

function automatic logic expected_vsync(input int l, input int p);
   return (l == VS_LINE && p >= 1) || l == VS_LINE + 1 || (l == VS_LINE + 2 && p == 0);
endfunction

// File: verification/video_tb.sv
`timescale 1ns/1ps

module video_tb;
   import video_timing_pkg::*;

   localparam int          CLK_PERIOD = 40;
   localparam int          FRAME_CLKS = 800 * 525;
   localparam int          APB_XFERS  = 16 * 4 * 12 + 1920 + 32;   // font, display, regs
   localparam longint      WATCHDOG_NS =
      (6 * longint'(FRAME_CLKS) + longint'(APB_XFERS) * 8 + 8) * CLK_PERIOD;
   localparam logic [13:0] OPREG  = 14'h2000;
   localparam logic [13:0] MODREG = 14'h2004;

   logic        vga_clk;
   logic        rst_n;
   logic        psel, penable, pwrite;
   logic [13:0] paddr;
   logic [7:0]  pwdata;
   logic        pready;
   logic [7:0]  prdata;
   logic        pslverr;
   logic        pixel_data, h_sync, v_sync;

   int          err_apb, err_sync, err_pix;
   string       test_name;
   logic [31:0] lfsr_state;
   logic [7:0]  codes [0:15];             // character set on screen

   // raster position of the clock that just ended
   logic        locked, vs_prev, checking, check_req;
   int          mon_pos, mon_line;

   `include "video_model.svh"

   video_top video_top_inst (.*);

   initial
   begin
      vga_clk = 1'b0;
      forever #(CLK_PERIOD / 2) vga_clk = ~vga_clk;
   end

   // 32 bit Galois LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);   // one step per bit
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic apb_xfer(input logic wr, input logic [13:0] addr, input logic [7:0] wdata,
                           output logic [7:0] rdata);
      int   edges;
      logic err;
      @(posedge vga_clk);
      psel    <= 1'b1;                      // setup phase
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge vga_clk);
      penable <= 1'b1;
      edges = 0;
      do
      begin
         @(posedge vga_clk);
         edges++;
      end
      while (!pready && edges < 8);
      rdata = prdata;
      err   = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
      assert (pready === 1'b1) else
      begin
         err_apb++;
         $display("apb transfer at %h never got pready", addr);
      end
      assert (edges == 2) else
      begin
         err_apb++;
         $display("mismatch %s wait states at %h: expected 1, actual %0d",
                  test_name, addr, edges - 1);
      end
      assert (err === (addr_region(addr) == 4)) else
      begin
         err_apb++;
         $display("mismatch %s pslverr at %h: expected %0b, actual %0b",
                  test_name, addr, addr_region(addr) == 4, err);
      end
      if (wr && addr_region(addr) != 4)
         model_write(addr, wdata);          // lands on the pready edge
   endtask

   task automatic apb_write(input logic [13:0] addr, input logic [7:0] data);
      logic [7:0] unused_rd;
      apb_xfer(1'b1, addr, data, unused_rd);
   endtask

   task automatic read_check(input logic [13:0] addr, input logic [7:0] exp);
      logic [7:0] rd;
      apb_xfer(1'b0, addr, 8'h00, rd);
      assert (rd === exp) else
      begin
         err_apb++;
         $display("mismatch %s read %h: expected %h, actual %h", test_name, addr, exp, rd);
      end
   endtask

   // arms the checker, returns once line 0 of that frame is under test
   task automatic start_checked_frame(input string name);
      @(negedge vga_clk);
      test_name = name;
      check_req = 1'b1;
      wait (checking);
   endtask

   always @(posedge vga_clk)
   begin
      logic exp_hs;
      logic exp_vs;
      logic exp_pix;
      if (locked)
      begin
         mon_pos++;
         if (mon_pos == 800)
         begin
            mon_pos  = 0;
            mon_line = (mon_line == 524) ? 0 : mon_line + 1;
         end
      end
      else if (v_sync && !vs_prev)
      begin
         locked   = 1'b1;                   // first v_sync edge fixes the raster
         mon_line = VS_LINE;
         mon_pos  = 1;
      end
      vs_prev = v_sync;
      if (locked)
      begin
         exp_hs = expected_hsync(mon_pos);
         exp_vs = expected_vsync(mon_line, mon_pos);
         assert (h_sync === exp_hs && v_sync === exp_vs) else
         begin
            err_sync++;
            if (err_sync <= 10)
               $display("mismatch %s sync at line %0d pos %0d: expected %0b%0b, actual %0b%0b",
                        test_name, mon_line, mon_pos, exp_hs, exp_vs, h_sync, v_sync);
         end
         if (checking)
         begin
            exp_pix = expected_pixel(mon_line, mon_pos);
            assert (pixel_data === exp_pix) else
            begin
               err_pix++;
               if (err_pix <= 10)
                  $display("mismatch %s pixel at line %0d pos %0d: expected %0b, actual %0b",
                           test_name, mon_line, mon_pos, exp_pix, pixel_data);
            end
            if (mon_line == 479 && mon_pos == 799)
               checking = 1'b0;             // rest of the frame is blank
         end
         if (mon_line == 524 && mon_pos == 799)
         begin
            m_frame_80 = m_opreg[2];        // mode switch at frame end
            checking   = check_req;
            check_req  = 1'b0;
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not reach its end in time");
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      logic [7:0] b;
      logic [7:0] idx;
      logic [7:0] v;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      rst_n      = 1'b0;
      lfsr_state = 32'd73021;
      err_apb    = 0;
      err_sync   = 0;
      err_pix    = 0;
      locked     = 1'b0;
      vs_prev    = 1'b0;
      checking   = 1'b0;
      check_req  = 1'b0;
      mon_pos    = 0;
      mon_line   = 0;
      m_opreg    = 8'h00;
      m_modreg   = 8'h00;
      m_frame_80 = 1'b0;
      test_name  = "reset";
      repeat (8) @(posedge vga_clk);
      rst_n <= 1'b1;

      test_name = "apb_regs";
      v = rand_bits(8);
      apb_write(OPREG, v);
      read_check(OPREG, v);
      v = rand_bits(8);
      apb_write(MODREG, v);
      read_check(MODREG, v);
      apb_write(14'h2008, 8'h5a);          // unmapped
      apb_write(14'h3000, 8'h5a);
      read_check(OPREG, m_opreg);           // untouched by the bad writes
      read_check(14'h0123, 8'hff);
      read_check(14'h1abc, 8'hff);
      apb_write(OPREG, 8'h00);
      apb_write(MODREG, 8'h00);

      // four of each top-bit pair, so text, alt, inverse and blocks all show
      test_name = "fill";
      for (int i = 0; i < 16; i++)
      begin
         v = rand_bits(6);
         codes[i] = {2'(i), v[5:0]};
         b = codes[i];
         for (int k = 0; k < 4; k++)
         begin
            for (int r = 0; r < 12; r++)
            begin
               idx = {k[1] ? b[7] : 1'b0, k[0] ? b[6] : (b[6] & ~b[7]), b[5:0]};
               v = rand_bits(8);
               apb_write(14'h1000 + {idx, 4'(r)}, v);
            end
         end
      end
      for (int a = 0; a < 1920; a++)
      begin
         v = rand_bits(4);
         apb_write(14'(a), codes[v[3:0]]);
      end

      start_checked_frame("text_64x16");
      wait (mon_line >= 100);
      @(negedge vga_clk);
      apb_write(OPREG, 8'h04);              // mode_80 mid frame
      wait (!checking);
      start_checked_frame("mode_80x24");
      wait (!checking);
      apb_write(OPREG, 8'h0c);
      apb_write(MODREG, 8'h08);
      start_checked_frame("inverse_altset");
      wait (!checking);
      apb_write(OPREG, 8'h04);
      start_checked_frame("altset_blocks");
      wait (!checking);
      apb_write(OPREG, 8'h00);
      apb_write(MODREG, 8'h04);
      start_checked_frame("double_width");
      wait (!checking);

      $display("errors: apb %0d, sync %0d, pixel %0d", err_apb, err_sync, err_pix);
      if (err_apb + err_sync + err_pix == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: source/video_top.sv
`timescale 1ns/1ps

module video_top (
   input  logic                              vga_clk,
   input  logic                              rst_n,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [video_regs_pkg::APB_AW-1:0] paddr,
   input  logic [video_regs_pkg::APB_DW-1:0] pwdata,
   output logic                              pready,
   output logic [video_regs_pkg::APB_DW-1:0] prdata,
   output logic                              pslverr,
   output logic                              pixel_data,
   output logic                              h_sync,
   output logic                              v_sync
);
   import video_timing_pkg::*;
   import video_regs_pkg::*;

   // register port to video
   logic              mode_80_req, invvide, modsel, enaltset;
   logic              dsp_we, font_we;
   logic [APB_AW-1:0] wr_addr;
   logic [APB_DW-1:0] wr_data;

   // raster position
   pix_t              pix;
   col_t              col;
   line_t             line;
   row_t              row;
   logic              mode_80, dsp_act, fetch_en;

   // fetched character
   logic [7:0]        glyph;
   char_code_u        code;
   logic [3:0]        font_row;

   apb_reg_fsm apb_reg_fsm_inst (.*);

   raster_counter raster_counter_inst (.*);

   char_fetch char_fetch_inst (.*);

   pixel_shifter pixel_shifter_inst (.*);

endmodule

// File: source/pixel_shifter.sv
`timescale 1ns/1ps

module pixel_shifter (
   input  logic                        vga_clk,
   input  logic                        rst_n,
   input  video_timing_pkg::pix_t      pix,
   input  logic                        dsp_act,
   input  logic                        fetch_en,
   input  logic                        modsel,
   input  logic                        invvide,
   input  logic [7:0]                  glyph,
   input  video_regs_pkg::char_code_u  code,
   input  logic [3:0]                  font_row,
   output logic                        pixel_data
);
   import video_timing_pkg::*;
   import video_regs_pkg::*;

   logic [7:0] shift_q;
   logic [7:0] load_val;
   logic       is_block;
   logic       load_slot;
   logic       shift_en;

   // block graphics only without inverse video
   assign is_block  = (code.block.prefix == BLOCK_PREFIX) && !invvide;
   assign load_slot = (pix == pix_t'(LOAD_PIX));
   assign shift_en  = !modsel || !pix[0];   // load slot is even so it also shifts

   always_comb
   begin
      if (is_block)
      begin
         // four font rows per cell pair, even cell on the left
         case (font_row[3:2])
            2'd0:    load_val = {{4{code.block.cells[0]}}, {4{code.block.cells[1]}}};
            2'd1:    load_val = {{4{code.block.cells[2]}}, {4{code.block.cells[3]}}};
            2'd2:    load_val = {{4{code.block.cells[4]}}, {4{code.block.cells[5]}}};
            default: load_val = '0;
         endcase
      end
      else
      begin
         load_val = (font_row >= 4'(GLYPH_ROWS)) ? 8'h00 : glyph;
         if (code.text.inv && invvide)
            load_val = ~load_val;
      end
   end

   always_ff @(posedge vga_clk or negedge rst_n)
   begin
      if (!rst_n)
         shift_q <= '0;
      else if (load_slot && fetch_en)
         shift_q <= load_val;              // first pixel out at pix 5
      else if (load_slot && !dsp_act)
         shift_q <= '0;                    // blank outside the text area
      else if (shift_en)
         shift_q <= {shift_q[6:0], 1'b0};
   end

   assign pixel_data = shift_q[7];

endmodule

// File: source/char_fetch.sv
`timescale 1ns/1ps

module char_fetch (
   input  logic                              vga_clk,
   input  logic                              rst_n,
   input  logic [video_regs_pkg::APB_AW-1:0] wr_addr,
   input  logic [video_regs_pkg::APB_DW-1:0] wr_data,
   input  logic                              dsp_we,
   input  logic                              font_we,
   input  video_timing_pkg::col_t            col,
   input  video_timing_pkg::line_t           line,
   input  video_timing_pkg::row_t            row,
   input  logic                              mode_80,
   input  logic                              fetch_en,
   input  video_timing_pkg::pix_t            pix,
   input  logic                              invvide,
   input  logic                              enaltset,
   output logic [7:0]                        glyph,
   output video_regs_pkg::char_code_u        code,
   output logic [3:0]                        font_row
);
   import video_regs_pkg::*;

   logic [APB_DW-1:0]  dsp_ram  [0:(1<<DSP_AW)-1];
   logic [APB_DW-1:0]  font_ram [0:(1<<FONT_AW)-1];

   logic [DSP_AW-1:0]  addr_80;
   logic [DSP_AW-1:0]  addr_64;
   logic [DSP_AW-1:0]  dsp_rd_addr;
   logic [FONT_AW-1:0] font_addr;
   logic [7:0]         font_idx;
   logic [3:0]         row_idx;
   logic               dsp_rd;
   logic               font_rd;
   char_code_u         dsp_q;          // display byte read at pix 0

   // row*80 + col as row*64 + row*16 + col
   assign addr_80 = (DSP_AW'(row) << 6) + (DSP_AW'(row) << 4) + DSP_AW'(col);
   assign addr_64 = {1'b0, row[3:0], col[5:0]};
   assign dsp_rd_addr = mode_80 ? addr_80 : addr_64;

   assign dsp_rd  = fetch_en && (pix == 3'd0);
   assign font_rd = fetch_en && (pix == 3'd2);

   assign row_idx = line[4:1];        // each font row is shown on two lines

   // inverse and alternate bits masked by the mode registers
   assign font_idx = {dsp_q.text.inv & ~invvide,
                      dsp_q.text.alt & ~(enaltset & dsp_q.text.inv),
                      dsp_q.text.code};
   assign font_addr = {font_idx, row_idx};

   // display RAM
   always_ff @(posedge vga_clk)
   begin
      if (dsp_we)
         dsp_ram[wr_addr[DSP_AW-1:0]] <= wr_data;
      if (dsp_rd)
         dsp_q <= dsp_ram[dsp_rd_addr];
   end

   // font RAM
   always_ff @(posedge vga_clk)
   begin
      if (font_we)
         font_ram[wr_addr[FONT_AW-1:0]] <= wr_data;
      if (font_rd)
         glyph <= font_ram[font_addr];
   end

   // code and row follow the font read so all three line up at pix 4
   always_ff @(posedge vga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         code     <= '0;
         font_row <= '0;
      end
      else if (font_rd)
      begin
         code     <= dsp_q;
         font_row <= row_idx;
      end
   end

endmodule

// File: source/raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
   input  logic                     vga_clk,
   input  logic                     rst_n,
   input  logic                     mode_80_req,
   input  logic                     modsel,
   output video_timing_pkg::pix_t   pix,
   output video_timing_pkg::col_t   col,
   output video_timing_pkg::line_t  line,
   output video_timing_pkg::row_t   row,
   output logic                     mode_80,
   output logic                     dsp_act,
   output logic                     fetch_en,
   output logic                     h_sync,
   output logic                     v_sync
);
   import video_timing_pkg::*;

   col_t                   col_cnt;     // raw column 0..99
   row_t                   row_cnt;     // raw char row
   col_t                   ofs_col;     // column inside the 64x16 window
   row_t                   ofs_row;
   line_t                  line_last;
   logic                   frame_end;
   logic [COL_W+PIX_W-1:0] h_pos;
   row_t                   vs_row;

   assign line_last = mode_80 ? line_t'(ROWS_80 - 1) : line_t'(ROWS_64 - 1);

   always_comb
   begin
      if (mode_80)
         frame_end = (row_cnt == row_t'(END_ROW_80)) && (line == line_t'(END_LINE_80));
      else
         frame_end = (row_cnt == row_t'(END_ROW_64)) && (line == line_t'(END_LINE_64));
   end

   always_ff @(posedge vga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pix     <= '0;
         col_cnt <= '0;
         line    <= '0;
         row_cnt <= '0;
         mode_80 <= 1'b0;                 // comes up in 64x16
      end
      else
      begin
         pix <= pix + pix_t'(1);
         if (pix == '1)
         begin
            if (col_cnt == col_t'(H_COLS_TOTAL - 1))
            begin
               col_cnt <= '0;
               if (frame_end)
               begin
                  line    <= '0;
                  row_cnt <= '0;
                  mode_80 <= mode_80_req;  // mode only switches between frames
               end
               else if (line == line_last)
               begin
                  line    <= '0;
                  row_cnt <= row_cnt + row_t'(1);
               end
               else
                  line <= line + line_t'(1);
            end
            else
               col_cnt <= col_cnt + col_t'(1);
         end
      end
   end

   assign ofs_col = col_cnt - col_t'(COL_OFS_64);   // wraps high left of window
   assign ofs_row = row_cnt - row_t'(ROW_OFS_64);

   // display coordinates for the fetch
   assign col = mode_80 ? col_cnt : ofs_col;
   assign row = mode_80 ? row_cnt : ofs_row;

   always_comb
   begin
      if (mode_80)
         dsp_act = (col_cnt < col_t'(COLS_ACT_80)) && (row_cnt < row_t'(CROWS_ACT_80));
      else
         dsp_act = (ofs_col < col_t'(COLS_ACT_64)) && (ofs_row < row_t'(CROWS_ACT_64));
   end

   assign fetch_en = dsp_act && (!modsel || !col[0]);   // double width skips odd cols

   assign h_pos  = {col_cnt, pix};
   assign vs_row = mode_80 ? row_t'(V_SYNC_ROW_80) : row_t'(V_SYNC_ROW_64);

   always_ff @(posedge vga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         h_sync <= 1'b0;
         v_sync <= 1'b0;
      end
      else
      begin
         if (h_pos == (COL_W+PIX_W)'(H_SYNC_START))
            h_sync <= 1'b1;
         else if (h_pos == (COL_W+PIX_W)'(H_SYNC_END))
            h_sync <= 1'b0;

         // frame line 489 to 491 in both modes
         if (row_cnt == vs_row && line == line_t'(V_SYNC_LINE_START))
            v_sync <= 1'b1;
         else if (row_cnt == vs_row && line == line_t'(V_SYNC_LINE_END))
            v_sync <= 1'b0;
      end
   end

endmodule

// File: source/apb_reg_fsm.sv
`timescale 1ns/1ps

module apb_reg_fsm (
   input  logic                               vga_clk,
   input  logic                               rst_n,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [video_regs_pkg::APB_AW-1:0]  paddr,
   input  logic [video_regs_pkg::APB_DW-1:0]  pwdata,
   output logic                               pready,
   output logic [video_regs_pkg::APB_DW-1:0]  prdata,
   output logic                               pslverr,
   output logic                               mode_80_req,
   output logic                               invvide,
   output logic                               modsel,
   output logic                               enaltset,
   output logic                               dsp_we,
   output logic                               font_we,
   output logic [video_regs_pkg::APB_AW-1:0]  wr_addr,
   output logic [video_regs_pkg::APB_DW-1:0]  wr_data
);
   import video_regs_pkg::*;

   localparam logic [1:0] IDLE   = 2'd0;
   localparam logic [1:0] SETUP  = 2'd1;   // the single wait cycle
   localparam logic [1:0] ACCESS = 2'd2;   // pready cycle

   logic [1:0]        state;
   logic              start;               // bus in its setup phase
   logic              sel_dsp, sel_font, sel_op, sel_mod;
   logic              write_q;
   logic              dsp_hit, font_hit, op_hit, mod_hit;
   logic              wr_fire;
   logic [APB_DW-1:0] opreg;
   logic [APB_DW-1:0] modreg;

   assign start = psel && !penable;

   // map decode on the live address
   assign sel_dsp  = paddr[APB_AW-1:DSP_AW] == DSP_BASE[APB_AW-1:DSP_AW];
   assign sel_font = paddr[APB_AW-1:FONT_AW] == FONT_BASE[APB_AW-1:FONT_AW];
   assign sel_op   = paddr == OPREG_ADDR;
   assign sel_mod  = paddr == MODREG_ADDR;

   always_ff @(posedge vga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= IDLE;
         write_q  <= 1'b0;
         dsp_hit  <= 1'b0;
         font_hit <= 1'b0;
         op_hit   <= 1'b0;
         mod_hit  <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (start)
               begin
                  state    <= SETUP;
                  write_q  <= pwrite;
                  dsp_hit  <= sel_dsp;
                  font_hit <= sel_font;
                  op_hit   <= sel_op;
                  mod_hit  <= sel_mod;
               end
            end
            SETUP:   state <= (psel && penable) ? ACCESS : IDLE;   // master dropped out
            default: state <= IDLE;
         endcase
      end
   end

   // address and data held for the write strobe
   always_ff @(posedge vga_clk)
   begin
      if (state == IDLE && start)
      begin
         wr_addr <= paddr;
         wr_data <= pwdata;
      end
   end

   assign pready  = (state == ACCESS);
   assign pslverr = pready && !(dsp_hit || font_hit || op_hit || mod_hit);
   assign wr_fire = pready && write_q;      // lands on the pready edge
   assign dsp_we  = wr_fire && dsp_hit;
   assign font_we = wr_fire && font_hit;

   always_ff @(posedge vga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         opreg  <= '0;
         modreg <= '0;
      end
      else
      begin
         if (wr_fire && op_hit)
            opreg <= wr_data;
         if (wr_fire && mod_hit)
            modreg <= wr_data;
      end
   end

   always_comb
   begin
      if (op_hit)
         prdata = opreg;
      else if (mod_hit)
         prdata = modreg;
      else
         prdata = RD_UNDRIVEN;             // RAM and unmapped reads
   end

   assign mode_80_req = opreg[OP_MODE_80_BIT];
   assign invvide     = opreg[OP_INVVIDE_BIT];
   assign modsel      = modreg[MOD_MODSEL_BIT];
   assign enaltset    = modreg[MOD_ENALTSET_BIT];

endmodule

// File: source/video_regs_pkg.sv
package video_regs_pkg;

   localparam int APB_AW = 14;
   localparam int APB_DW = 8;

   // memory sizes as address bits
   localparam int DSP_AW  = 11;     // 2 KB display RAM
   localparam int FONT_AW = 12;     // 4 KB font RAM

   // address map
   localparam logic [APB_AW-1:0] DSP_BASE    = 14'h0000;
   localparam logic [APB_AW-1:0] FONT_BASE   = 14'h1000;
   localparam logic [APB_AW-1:0] OPREG_ADDR  = 14'h2000;
   localparam logic [APB_AW-1:0] MODREG_ADDR = 14'h2004;

   // RAM reads behave like an undriven bus
   localparam logic [APB_DW-1:0] RD_UNDRIVEN = 8'hff;

   // opreg fields
   localparam int OP_MODE_80_BIT = 2;
   localparam int OP_INVVIDE_BIT = 3;

   // modreg fields
   localparam int MOD_MODSEL_BIT   = 2;   // 32/40 column double width
   localparam int MOD_ENALTSET_BIT = 3;

   localparam logic [1:0] BLOCK_PREFIX = 2'b10;

   // one display byte, decoded as text or as 2x3 block graphic
   typedef union packed {
      struct packed {
         logic       inv;     // inverse video bit
         logic       alt;     // alternate set bit
         logic [5:0] code;
      } text;
      struct packed {
         logic [1:0] prefix;
         logic [5:0] cells;   // bit 0 top left, bit 5 bottom right
      } block;
   } char_code_u;

endpackage

// File: source/video_timing_pkg.sv
package video_timing_pkg;

   // counter widths
   localparam int PIX_W  = 3;
   localparam int COL_W  = 7;
   localparam int LINE_W = 5;
   localparam int ROW_W  = 5;

   typedef logic [PIX_W-1:0]  pix_t;    // pixel within a character
   typedef logic [COL_W-1:0]  col_t;    // character column
   typedef logic [LINE_W-1:0] line_t;   // scan line within a char row
   typedef logic [ROW_W-1:0]  row_t;    // character row

   localparam int H_COLS_TOTAL = 100;   // 800 clocks per line
   localparam int COLS_ACT_80  = 80;
   localparam int COLS_ACT_64  = 64;
   localparam int CROWS_ACT_80 = 24;
   localparam int CROWS_ACT_64 = 16;
   localparam int ROWS_80      = 20;    // 10 font rows shown twice
   localparam int ROWS_64      = 24;    // 12 font rows shown twice

   // last line of the frame, 525 lines in either mode
   localparam int END_ROW_80  = 26;
   localparam int END_LINE_80 = 4;
   localparam int END_ROW_64  = 21;
   localparam int END_LINE_64 = 20;

   localparam int COL_OFS_64 = 8;       // centers 64x16 horizontally
   localparam int ROW_OFS_64 = 2;

   localparam int H_SYNC_START      = 658;   // as col*8 + pix
   localparam int H_SYNC_END        = 754;
   localparam int V_SYNC_ROW_80     = 24;
   localparam int V_SYNC_ROW_64     = 20;
   localparam int V_SYNC_LINE_START = 9;
   localparam int V_SYNC_LINE_END   = 11;

   localparam int LOAD_PIX   = 4;       // shifter load slot
   localparam int GLYPH_ROWS = 12;      // font rows past this are blank

endpackage
